/* source/eth_pkg.sv */
package eth_pkg;

	// switch ports
	localparam int NUM_PORTS = 4;
	localparam int PORT_W    = $clog2(NUM_PORTS);

	// MAC address, first byte on the wire is the most significant
	localparam int MAC_BYTES = 6;
	localparam int MAC_W     = MAC_BYTES * 8;
	localparam int GROUP_BIT = MAC_W - 8;   // lsb of the first byte

	// parsed header is dmac then smac
	localparam int HDR_BYTES = 12;
	localparam int HDR_W     = HDR_BYTES * 8;
	localparam int HDR_CNT_W = $clog2(HDR_BYTES + 1);

	// table slot of a MAC is the low index bits of the XOR of its six bytes

	typedef logic [PORT_W-1:0]    port_id_t;
	typedef logic [NUM_PORTS-1:0] port_map_t;   // one bit per port
	typedef logic [MAC_W-1:0]     mac_addr_t;
	typedef logic [HDR_CNT_W-1:0] hdr_cnt_t;

	localparam hdr_cnt_t HDR_LAST = hdr_cnt_t'(HDR_BYTES - 1);

	// one received byte
	typedef struct packed {
		logic       sof;        // first byte of a frame
		logic       dv;
		logic [7:0] data;
		port_id_t   src_port;
	} rx_beat_t;

	typedef struct packed {
		logic      valid;       // one cycle strobe
		mac_addr_t dmac;
		mac_addr_t smac;
		port_id_t  src_port;
	} frame_hdr_t;

endpackage

/* source/fwd_pkg.sv */
package fwd_pkg;

	import eth_pkg::*;

	// direct mapped table
	// index of a MAC is the low TABLE_IDX_W bits of the XOR of its six bytes
	localparam int TABLE_IDX_W = 4;
	localparam int TABLE_DEPTH = 1 << TABLE_IDX_W;

	typedef logic [TABLE_IDX_W-1:0] table_idx_t;

	// one stored host
	typedef struct packed {
		logic      valid;
		mac_addr_t mac;
		port_id_t  port;
	} table_entry_t;

	// result of one destination lookup
	typedef struct packed {
		logic     valid;
		logic     hit;
		port_id_t dst_port;     // port stored in the table
		port_id_t src_port;     // port the frame came in on
		logic     dst_group;    // multicast or broadcast destination
	} lookup_t;

	// one forwarding decision per frame
	typedef struct packed {
		logic      valid;
		logic      flood;
		port_map_t ports;       // empty map means drop
	} fwd_result_t;

endpackage

/* source/frame_header_parser.sv */
`timescale 1ns/1ns

module frame_header_parser import eth_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  rx_beat_t   rx,
	output frame_hdr_t hdr
);

	logic         active;       // inside the first twelve bytes
	hdr_cnt_t     byte_cnt;     // header bytes taken so far
	logic         hdr_done;
	logic [HDR_W-1:0] hdr_sr;
	logic [HDR_W-1:0] hdr_next;
	port_id_t     src_port_q;

	logic         hdr_valid;
	mac_addr_t    dmac_q;
	mac_addr_t    smac_q;
	port_id_t     port_q;

	// every dv byte shifts in at the bottom
	assign hdr_next = {hdr_sr[HDR_W-9:0], rx.data};

	// twelfth byte of a frame still in progress
	assign hdr_done = active && rx.dv && !rx.sof && (byte_cnt == HDR_LAST);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active    <= 1'b0;
			byte_cnt  <= '0;
			hdr_valid <= 1'b0;
		end else begin
			hdr_valid <= hdr_done;
			if (rx.dv && rx.sof) begin
				active   <= 1'b1;   // restart, even mid header
				byte_cnt <= hdr_cnt_t'(1);
			end else if (!rx.dv) begin
				active <= 1'b0;     // gap drops a short header
			end else if (active) begin
				byte_cnt <= byte_cnt + hdr_cnt_t'(1);
				if (hdr_done)
					active <= 1'b0;   // payload ignored until next sof
			end
		end
	end

	// header bytes and the ingress port
	always_ff @(posedge clk) begin
		if (rx.dv)
			hdr_sr <= hdr_next;
		if (rx.dv && rx.sof)
			src_port_q <= rx.src_port;
	end

	always_ff @(posedge clk) begin
		if (hdr_done) begin
			dmac_q <= hdr_next[HDR_W-1 -: MAC_W];
			smac_q <= hdr_next[MAC_W-1:0];
			port_q <= src_port_q;
		end
	end

	assign hdr = '{
		valid:    hdr_valid,
		dmac:     dmac_q,
		smac:     smac_q,
		src_port: port_q
	};

	// twelve bytes separate two headers
	a_hdr_single: assert property (@(posedge clk) disable iff (!rst_n)
		hdr.valid |=> !hdr.valid);

endmodule

/* source/mac_table.sv */
`timescale 1ns/1ns

module mac_table import eth_pkg::*, fwd_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       table_clear,
	input  frame_hdr_t hdr,
	output lookup_t    lkp
);

	table_entry_t table_mem [TABLE_DEPTH];

	table_idx_t   dst_idx;
	table_idx_t   src_idx;
	table_entry_t rd_entry;     // destination slot
	table_entry_t rd_src;       // source slot before learning
	logic         learn;

	logic         lkp_valid;
	logic         lkp_hit;
	port_id_t     lkp_dst_port;
	port_id_t     lkp_src_port;
	logic         lkp_group;

	// fold the six bytes, keep the low bits
	function automatic table_idx_t mac_index(input mac_addr_t mac);
		logic [7:0] folded;
		folded = '0;
		for (int i = 0; i < MAC_BYTES; i++) begin
			folded = folded ^ mac[i*8 +: 8];
		end
		return folded[TABLE_IDX_W-1:0];
	endfunction

	assign dst_idx  = mac_index(hdr.dmac);
	assign src_idx  = mac_index(hdr.smac);
	assign rd_entry = table_mem[dst_idx];
	assign rd_src   = table_mem[src_idx];

	// group sources are never learned
	assign learn = hdr.valid && !hdr.smac[GROUP_BIT];

	// clear wins over a learn at the same edge
	always_ff @(posedge clk) begin
		if (!rst_n || table_clear) begin
			for (int i = 0; i < TABLE_DEPTH; i++) begin
				table_mem[i].valid <= 1'b0;
			end
		end else if (learn) begin
			table_mem[src_idx] <= '{
				valid: 1'b1,
				mac:   hdr.smac,
				port:  hdr.src_port
			};
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			lkp_valid <= 1'b0;
		else
			lkp_valid <= hdr.valid;
	end

	// rd_entry still holds the old contents here, so no self hit
	always_ff @(posedge clk) begin
		if (hdr.valid) begin
			lkp_hit      <= rd_entry.valid && (rd_entry.mac == hdr.dmac);
			lkp_dst_port <= rd_entry.port;
			lkp_src_port <= hdr.src_port;
			lkp_group    <= hdr.dmac[GROUP_BIT];
		end
	end

	assign lkp = '{
		valid:     lkp_valid,
		hit:       lkp_hit,
		dst_port:  lkp_dst_port,
		src_port:  lkp_src_port,
		dst_group: lkp_group
	};

	// a group source leaves its slot as it was
	a_no_group_learn: assert property (@(posedge clk) disable iff (!rst_n)
		hdr.valid && hdr.smac[GROUP_BIT] && !table_clear
		|=> table_mem[$past(src_idx)] === $past(rd_src));

endmodule

/* source/forward_decision.sv */
`timescale 1ns/1ns

module forward_decision import eth_pkg::*, fwd_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  port_map_t   link,
	input  lookup_t     lkp,
	output fwd_result_t fwd
);

	port_map_t src_bit;
	port_map_t dst_bit;
	port_map_t flood_map;
	port_map_t uc_map;
	logic      flood;

	logic      fwd_valid;
	logic      fwd_flood;
	port_map_t fwd_ports;

	assign src_bit = port_map_t'(1) << lkp.src_port;
	assign dst_bit = port_map_t'(1) << lkp.dst_port;

	// group or unknown destination goes everywhere
	assign flood = lkp.dst_group || !lkp.hit;

	assign flood_map = link & ~src_bit;
	assign uc_map    = dst_bit & link & ~src_bit;   // empty if same port or link down

	always_ff @(posedge clk) begin
		if (!rst_n)
			fwd_valid <= 1'b0;
		else
			fwd_valid <= lkp.valid;
	end

	always_ff @(posedge clk) begin
		if (lkp.valid) begin
			fwd_flood <= flood;
			fwd_ports <= flood ? flood_map : uc_map;
		end
	end

	assign fwd = '{
		valid: fwd_valid,
		flood: fwd_flood,
		ports: fwd_ports
	};

	// never sent back where it came from
	a_no_reflect: assert property (@(posedge clk) disable iff (!rst_n)
		fwd.valid |-> !fwd.ports[$past(lkp.src_port)]);

endmodule

/* source/l2_switch_core.sv */
`timescale 1ns/1ns

module l2_switch_core import eth_pkg::*, fwd_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  rx_beat_t    rx,
	input  port_map_t   link,
	input  logic        table_clear,
	output fwd_result_t fwd
);

	frame_hdr_t hdr;    // parser to table
	lookup_t    lkp;    // table to decision

	frame_header_parser frame_header_parser_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.rx    (rx),
		.hdr   (hdr)
	);

	mac_table mac_table_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.table_clear (table_clear),
		.hdr         (hdr),
		.lkp         (lkp)
	);

	forward_decision forward_decision_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.link  (link),
		.lkp   (lkp),
		.fwd   (fwd)
	);

endmodule

/* testbench/tb_l2_switch_core.sv */
`timescale 1ns/1ns

module tb_l2_switch_core import eth_pkg::*, fwd_pkg::*; ();

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 8;
	localparam int FRAME_COUNT  = 47;
	localparam int WATCHDOG_NS  = (FRAME_COUNT * 40 + RESET_CYCLES) * CLK_PERIOD;
	localparam logic [31:0] LFSR_SEED = 32'h5d6d7494;

	logic        clk = 1'b0;
	logic        rst_n;
	rx_beat_t    rx;
	port_map_t   link;
	logic        table_clear;
	fwd_result_t fwd;

	logic [31:0]  lfsr;
	int           cycle;            // falling edges since reset release
	int           exp_due [$];      // cycle in which each result is due
	fwd_result_t  exp_res [$];
	table_entry_t model_tab [TABLE_DEPTH];
	mac_addr_t    mac_s1, mac_a, mac_b, mac_c, mac_e, mac_h;

	l2_switch_core l2_switch_core_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.rx          (rx),
		.link        (link),
		.table_clear (table_clear),
		.fwd         (fwd)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [47:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val = {val[46:0], lfsr[0]};
		end
	endtask

	function automatic table_idx_t fold_index(input mac_addr_t mac);
		logic [7:0] x;
		x = '0;
		for (int i = 0; i < MAC_BYTES; i++)
			x = x ^ mac[8*i +: 8];
		return x[TABLE_IDX_W-1:0];
	endfunction

	// random MAC forced onto a chosen table slot
	task automatic rand_mac(input logic group, input table_idx_t idx, output mac_addr_t mac);
		logic [47:0] r;
		rand_bits(48, r);
		mac = r;
		mac[GROUP_BIT] = group;
		mac[TABLE_IDX_W-1:0] = mac[TABLE_IDX_W-1:0] ^ fold_index(mac) ^ idx;
	endtask

	function automatic fwd_result_t make_fwd(input logic flood, input port_map_t ports);
		return '{valid: 1'b1, flood: flood, ports: ports};
	endfunction

	function automatic fwd_result_t predict(input mac_addr_t dmac, input port_id_t sp,
			input port_map_t lk);
		table_entry_t e;
		port_map_t    keep;
		fwd_result_t  r;
		e = model_tab[fold_index(dmac)];
		keep = lk;
		keep[sp] = 1'b0;   // never back to the ingress port
		r.valid = 1'b1;
		r.flood = dmac[GROUP_BIT] || !(e.valid && e.mac == dmac);
		r.ports = '0;
		if (r.flood)
			r.ports = keep;
		else
			r.ports[e.port] = keep[e.port];
		return r;
	endfunction

	function automatic void learn_model(input mac_addr_t smac, input port_id_t sp);
		if (!smac[GROUP_BIT])
			model_tab[fold_index(smac)] = '{valid: 1'b1, mac: smac, port: sp};
	endfunction

	task automatic report_error(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_fwd(input fwd_result_t want);
		if (fwd !== want)
			report_error($sformatf("fwd valid %0b flood %0b ports %b, expected flood %0b ports %b",
				fwd.valid, fwd.flood, fwd.ports, want.flood, want.ports));
	endtask

	task automatic check_none();
		if (fwd.valid !== 1'b0)
			report_error($sformatf("unexpected result, flood %0b ports %b", fwd.flood, fwd.ports));
	endtask

	// one falling edge with the output check
	task automatic tick();
		fwd_result_t want;
		@(negedge clk);
		cycle++;
		if (exp_due.size() > 0 && exp_due[0] == cycle) begin
			want = exp_res.pop_front();
			exp_due.delete(0);
			check_fwd(want);
		end else begin
			check_none();
		end
	endtask

	task automatic idle(input int n);
		for (int i = 0; i < n; i++) begin
			tick();
			rx = '0;
		end
	endtask

	task automatic send_frame(input mac_addr_t dmac, input mac_addr_t smac, input port_id_t sp,
			input int len, input logic use_model, input fwd_result_t want);
		logic [HDR_W-1:0] hdr_bytes;
		logic [47:0]      pay;
		hdr_bytes = {dmac, smac};
		for (int i = 0; i < len; i++) begin
			tick();
			rx.sof = (i == 0);
			rx.dv = 1'b1;
			rx.src_port = sp;
			if (i < HDR_BYTES) begin
				rx.data = hdr_bytes[HDR_W-1-8*i -: 8];
			end else begin
				rand_bits(8, pay);
				rx.data = pay[7:0];
			end
			if (i == HDR_BYTES - 1) begin
				exp_due.push_back(cycle + 3);   // two stages after the sampling edge
				exp_res.push_back(use_model ? predict(dmac, sp, link) : want);
				learn_model(smac, sp);
			end
		end
	endtask

	task automatic send_directed(input mac_addr_t dmac, input mac_addr_t smac, input port_id_t sp,
			input logic flood, input port_map_t ports);
		send_frame(dmac, smac, sp, HDR_BYTES, 1'b0, make_fwd(flood, ports));
		idle(4);
	endtask

	task automatic clear_table();
		tick();
		table_clear = 1'b1;
		tick();
		table_clear = 1'b0;
		for (int i = 0; i < TABLE_DEPTH; i++)
			model_tab[i].valid = 1'b0;
	endtask

	task automatic unknown_unicast_test();
		mac_addr_t u;
		rand_mac(1'b0, 4'd1, u);
		rand_mac(1'b0, 4'd2, mac_s1);
		send_directed(u, mac_s1, 2'd1, 1'b1, 4'b1101);
	endtask

	task automatic learn_unicast_test();
		mac_addr_t u;
		rand_mac(1'b0, 4'd3, mac_a);
		rand_mac(1'b0, 4'd4, u);
		rand_mac(1'b0, 4'd5, mac_b);
		rand_mac(1'b0, 4'd6, mac_c);
		send_directed(u, mac_a, 2'd2, 1'b1, 4'b1011);
		send_directed(mac_a, mac_b, 2'd0, 1'b0, 4'b0100);
		send_directed(mac_a, mac_c, 2'd2, 1'b0, 4'b0000);   // same port drops
	endtask

	task automatic group_flood_test();
		mac_addr_t s, u, g, mc;
		rand_mac(1'b0, 4'd7, s);
		rand_mac(1'b0, 4'd8, mac_e);
		rand_mac(1'b1, 4'd8, g);   // group source on the slot of mac_e
		rand_mac(1'b0, 4'd0, u);
		rand_mac(1'b1, 4'd10, mc);
		send_directed('1, s, 2'd0, 1'b1, 4'b1110);
		send_directed(u, mac_e, 2'd1, 1'b1, 4'b1101);
		send_directed(u, g, 2'd3, 1'b1, 4'b0111);
		send_directed(mac_e, mac_b, 2'd0, 1'b0, 4'b0010);   // entry survived
		send_directed(mc, mac_c, 2'd2, 1'b1, 4'b1011);
	endtask

	task automatic link_mask_test();
		mac_addr_t u1, u2;
		rand_mac(1'b0, 4'd9, mac_h);
		rand_mac(1'b0, 4'd10, u1);
		rand_mac(1'b0, 4'd11, u2);
		link = 4'b0111;
		send_directed(u1, mac_h, 2'd3, 1'b1, 4'b0111);
		send_directed(u2, mac_b, 2'd0, 1'b1, 4'b0110);
		send_directed(mac_h, mac_s1, 2'd1, 1'b0, 4'b0000);
		link = '1;
	endtask

	task automatic collision_clear_test();
		mac_addr_t j, k, u;
		rand_mac(1'b0, 4'd13, j);
		rand_mac(1'b0, 4'd13, k);
		rand_mac(1'b0, 4'd14, u);
		send_directed(u, j, 2'd1, 1'b1, 4'b1101);
		send_directed(j, mac_b, 2'd0, 1'b0, 4'b0010);
		send_directed(u, k, 2'd2, 1'b1, 4'b1011);
		send_directed(j, mac_b, 2'd0, 1'b1, 4'b1110);   // evicted by k
		send_directed(k, mac_b, 2'd0, 1'b0, 4'b0100);
		clear_table();
		send_directed(k, mac_s1, 2'd1, 1'b1, 4'b1101);
		send_directed(mac_a, mac_h, 2'd3, 1'b1, 4'b0111);
		send_directed(mac_e, mac_c, 2'd2, 1'b1, 4'b1011);
	endtask

	task automatic short_and_burst_test();
		mac_addr_t   u, s;
		mac_addr_t   pool [6];
		logic [47:0] r;
		mac_addr_t   dmac;
		mac_addr_t   smac;
		port_id_t    sp;
		rand_mac(1'b0, 4'd12, u);
		rand_mac(1'b0, 4'd15, s);
		send_frame(u, s, 2'd1, 7, 1'b0, '0);   // dv gap cuts it
		idle(3);
		send_frame(u, s, 2'd2, 5, 1'b0, '0);   // cut by the next sof
		send_directed(u, s, 2'd3, 1'b1, 4'b0111);
		for (int i = 0; i < 5; i++)
			rand_mac(1'b0, table_idx_t'(3 * i), pool[i]);
		pool[5] = '1;
		for (int n = 0; n < 24; n++) begin
			rand_bits(3, r);
			dmac = pool[int'(r[2:0]) % 6];
			rand_bits(3, r);
			smac = pool[int'(r[2:0]) % 5];
			rand_bits(2, r);
			sp = r[1:0];
			rand_bits(3, r);
			send_frame(dmac, smac, sp, HDR_BYTES + int'(r[2:0]), 1'b1, '0);
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		rst_n = 1'b0;
		rx = '0;
		link = '1;
		table_clear = 1'b0;
		lfsr = LFSR_SEED;
		cycle = 0;
		for (int i = 0; i < TABLE_DEPTH; i++)
			model_tab[i] = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		unknown_unicast_test();
		learn_unicast_test();
		group_flood_test();
		link_mask_test();
		collision_clear_test();
		short_and_burst_test();
		idle(6);
		if (exp_due.size() == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			$display("%0d expected results were never seen", exp_due.size());
			$display("Simulation failed");
			$fatal(1, "results missing at the end");
		end
	end

endmodule

/* l2_switch_core.f */
source/eth_pkg.sv
source/fwd_pkg.sv
source/frame_header_parser.sv
source/mac_table.sv
source/forward_decision.sv
source/l2_switch_core.sv
testbench/tb_l2_switch_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert \
	--top-module tb_l2_switch_core -f l2_switch_core.f \
	> build.log 2>&1 \
	&& ./obj_dir/Vtb_l2_switch_core > sim.log 2>&1 \
	|| echo "build or simulation returned an error"

cat build.log sim.log 2>/dev/null
grep -qsx "Simulation completed successfully" sim.log && echo "PASS" && exit 0 \
	|| { echo "FAIL"; exit 1; }
